/* build.f */
+incdir+design
design/gb_io_pkg.sv
design/cpu_bus_if.sv
design/bus_read_mux.sv
design/irq_ctrl.sv
design/joypad.sv
design/serial_port.sv
design/work_ram.sv
design/gb_io_top.sv
verification/gb_io_chk.sv
verification/gb_io_monitor.sv
verification/gb_io_tb.sv

/* Makefile */
# Verilator flow for the io block testbench
VERILATOR  ?= verilator
TOP        := gb_io_tb
FILELIST   := build.f
BUILD_DIR  := obj_dir
LOG        := sim.log
LINT_FLAGS := --lint-only --timing --assert
SIM_FLAGS  := --binary --timing --assert -j 0
SIM_ARGS   := +verilator+error+limit+100
PASS_MSG   := *** TEST PASSED ***

.PHONY: lint sim clean

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR) -o $(TOP)
	./$(BUILD_DIR)/$(TOP) $(SIM_ARGS) 2>&1 | tee $(LOG)
	@grep -qF '$(PASS_MSG)' $(LOG) && echo "sim passed" || (echo "sim failed" && exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* verification/gb_io_tb.sv */
// table driven test of the io block, inputs change on the falling edge
// each table row takes two cycles, serial wait polls SC up to 6000 cycles
`timescale 1ns/1ps

module gb_io_tb;

	typedef enum {op_wr, op_rd, op_pulse, op_joy, op_gbc, op_ack, op_irq, op_serial} op_t;

	logic        clk_cpu = 1'b0;
	logic        reset, is_gbc, wr, rd, irq_ack;
	logic [15:0] addr;
	logic [7:0]  wdata, joystick, rdata;
	logic [2:0]  irq_src;
	logic        irq_n;
	int          mon_errors, mon_checks;
	int          wait_fails = 0;

	// stimulus table, one entry per row in every queue
	string       row_name[$];
	op_t         row_op[$];
	logic [15:0] row_addr[$];
	logic [7:0]  row_data[$];
	logic [7:0]  row_exp[$];

	always #5 clk_cpu = ~clk_cpu;  // 10 ns

	gb_io_top gb_io_top_inst (
		.clk_cpu  (clk_cpu),
		.reset    (reset),
		.is_gbc   (is_gbc),
		.addr     (addr),
		.wdata    (wdata),
		.wr       (wr),
		.rd       (rd),
		.irq_ack  (irq_ack),
		.irq_src  (irq_src),
		.joystick (joystick),
		.rdata    (rdata),
		.irq_n    (irq_n)
	);

	gb_io_monitor mon (
		.clk_cpu (clk_cpu),
		.rdata   (rdata),
		.irq_n   (irq_n),
		.errors  (mon_errors),
		.checks  (mon_checks)
	);

	// --------------------
	// expected values from the register rules
	function automatic logic [7:0] joyp_value(input logic [7:0] joy, input logic [1:0] sel);
		logic [3:0] lines;
		lines = 4'hF;
		if (!sel[0])
			lines = lines & ~joy[3:0];  // directions selected
		if (!sel[1])
			lines = lines & ~joy[7:4];  // buttons selected
		return {2'b11, sel, lines};
	endfunction

	function automatic logic [7:0] if_value(input logic [4:0] mask);
		return {3'b111, mask};
	endfunction

	function automatic logic [7:0] sc_value(input logic start, input logic int_clk);
		return {start, 6'b111111, int_clk};
	endfunction

	function automatic logic [7:0] vec_value(input int idx);
		return 8'(8'h40 + 8 * idx);
	endfunction

	task automatic add_step(input string name, input op_t op, input logic [15:0] a,
		input logic [7:0] d, input logic [7:0] e);
		row_name.push_back(name);
		row_op.push_back(op);
		row_addr.push_back(a);
		row_data.push_back(d);
		row_exp.push_back(e);
	endtask

	// --------------------
	task automatic build_table();
		logic [7:0] b2, b5, b1, echo_b, h0, h1;
		logic [7:0] joy;
		b2     = 8'($urandom);
		b5     = ~b2;           // every bank holds a different byte
		b1     = b2 ^ 8'h5A;
		echo_b = 8'($urandom);
		h0     = 8'($urandom);
		h1     = ~h0;
		joy    = 8'h69;         // right, down, B, select held

		add_step("reset_irq_n", op_irq, 16'h0000, 8'h00, 8'h01);
		add_step("reset_idle_rd", op_rd, 16'h0000, 8'h00, 8'hFF);
		// banking
		add_step("gbc_on", op_gbc, 16'h0000, 8'h01, 8'h00);
		add_step("bank2_sel", op_wr, 16'hFF70, 8'h02, 8'h00);
		add_step("bank2_wr", op_wr, 16'hD000, b2, 8'h00);
		add_step("bank5_sel", op_wr, 16'hFF70, 8'h05, 8'h00);
		add_step("bank5_wr", op_wr, 16'hD000, b5, 8'h00);
		add_step("bank5_rd", op_rd, 16'hD000, 8'h00, b5);
		add_step("bank2_reselect", op_wr, 16'hFF70, 8'h02, 8'h00);
		add_step("bank2_rd", op_rd, 16'hD000, 8'h00, b2);
		add_step("bank0_sel", op_wr, 16'hFF70, 8'h00, 8'h00);
		add_step("svbk_rd", op_rd, 16'hFF70, 8'h00, {5'b11111, 3'd1});
		add_step("bank1_wr", op_wr, 16'hD000, b1, 8'h00);
		add_step("bank5_before_dmg", op_wr, 16'hFF70, 8'h05, 8'h00);
		add_step("gbc_off", op_gbc, 16'h0000, 8'h00, 8'h00);
		add_step("svbk_dmg_rd", op_rd, 16'hFF70, 8'h00, 8'hFF);
		add_step("dmg_bank1_rd", op_rd, 16'hD000, 8'h00, b1);
		// echo and high ram
		add_step("echo_wr", op_wr, 16'hC123, echo_b, 8'h00);
		add_step("echo_rd", op_rd, 16'hE123, 8'h00, echo_b);
		add_step("hram_lo_wr", op_wr, 16'hFF80, h0, 8'h00);
		add_step("hram_hi_wr", op_wr, 16'hFFFE, h1, 8'h00);
		add_step("hram_lo_rd", op_rd, 16'hFF80, 8'h00, h0);
		add_step("hram_hi_rd", op_rd, 16'hFFFE, 8'h00, h1);
		// joypad, all four select combinations
		add_step("joy_press", op_joy, 16'h0000, joy, 8'h00);
		for (int s = 0; s < 4; s++) begin
			add_step($sformatf("joyp_sel%0d_wr", s), op_wr, 16'hFF00, 8'(s << 4), 8'h00);
			add_step($sformatf("joyp_sel%0d_rd", s), op_rd, 16'hFF00, 8'h00,
				joyp_value(joy, 2'(s)));
		end
		// priority and acknowledge
		add_step("if_clear", op_wr, 16'hFF0F, 8'h00, 8'h00);
		add_step("ie_all", op_wr, 16'hFFFF, 8'h1F, 8'h00);
		add_step("ie_rd", op_rd, 16'hFFFF, 8'h00, 8'h1F);
		add_step("pulse_lcd_timer", op_pulse, 16'h0000, 8'h06, 8'h00);
		add_step("if_pending_rd", op_rd, 16'hFF0F, 8'h00, if_value(5'b00110));
		add_step("irq_n_pending", op_irq, 16'h0000, 8'h00, 8'h00);
		add_step("ack_lcd_vec", op_ack, 16'h0000, 8'h00, vec_value(1));
		add_step("if_after_ack_rd", op_rd, 16'hFF0F, 8'h00, if_value(5'b00100));
		add_step("ack_timer_vec", op_ack, 16'h0000, 8'h00, vec_value(2));
		add_step("pulse_vblank", op_pulse, 16'h0000, 8'h01, 8'h00);
		add_step("irq_n_vblank", op_irq, 16'h0000, 8'h00, 8'h00);
		add_step("if_write_zero", op_wr, 16'hFF0F, 8'h00, 8'h00);
		add_step("irq_n_released", op_irq, 16'h0000, 8'h00, 8'h01);
		// serial transfer
		add_step("sc_start", op_wr, 16'hFF02, 8'h81, 8'h00);
		add_step("sc_busy_rd", op_rd, 16'hFF02, 8'h00, sc_value(1'b1, 1'b1));
		add_step("sc_wait_done", op_serial, 16'hFF02, 8'h00, 8'h00);
		add_step("sc_done_rd", op_rd, 16'hFF02, 8'h00, sc_value(1'b0, 1'b1));
		add_step("if_serial_rd", op_rd, 16'hFF0F, 8'h00, if_value(5'b01000));
		// joypad interrupt on a selected direction line
		add_step("joy_release", op_joy, 16'h0000, 8'h00, 8'h00);
		add_step("joyp_dir_sel", op_wr, 16'hFF00, 8'h20, 8'h00);
		add_step("if_clear_joy", op_wr, 16'hFF0F, 8'h00, 8'h00);
		add_step("joy_press_up", op_joy, 16'h0000, 8'h04, 8'h00);
		add_step("if_joypad_rd", op_rd, 16'hFF0F, 8'h00, if_value(5'b10000));
	endtask

	// --------------------
	// poll SC until the start bit drops
	task automatic wait_serial(input string name);
		int   cycles;
		logic busy;
		busy   = 1'b1;
		cycles = 0;
		while (busy && cycles < 6000) begin
			addr = 16'hFF02;
			rd   = 1'b1;
			@(negedge clk_cpu);
			rd   = 1'b0;
			busy = rdata[7];
			@(negedge clk_cpu);
			cycles += 2;
		end
		if (busy) begin
			$display("%s: serial transfer still running after 6000 cycles", name);
			wait_fails++;
		end
	endtask

	task automatic apply_row(input int i);
		@(negedge clk_cpu);
		addr  = row_addr[i];
		wdata = row_data[i];
		case (row_op[i])
			op_wr:    wr = 1'b1;
			op_rd: begin
				rd = 1'b1;
				mon.expect_byte(row_name[i], row_exp[i], 1'b0);
			end
			op_pulse: irq_src = row_data[i][2:0];
			op_joy:   joystick = row_data[i];
			op_gbc:   is_gbc = row_data[i][0];
			op_ack: begin
				irq_ack = 1'b1;  // vector comes back instead of the read
				rd      = 1'b1;
				mon.expect_byte(row_name[i], row_exp[i], 1'b0);
			end
			op_irq:    mon.expect_byte(row_name[i], row_exp[i], 1'b1);
			op_serial: wait_serial(row_name[i]);
			default:   ;
		endcase
		@(negedge clk_cpu);
		wr      = 1'b0;
		rd      = 1'b0;
		irq_ack = 1'b0;  // falling ack clears the flag at the next edge
		irq_src = 3'b000;
	endtask

	// --------------------
	initial begin
		int chk_fails;
		int total;
		void'($urandom(96046));
		reset    = 1'b1;
		is_gbc   = 1'b0;
		addr     = 16'h0000;
		wdata    = 8'h00;
		wr       = 1'b0;
		rd       = 1'b0;
		irq_ack  = 1'b0;
		irq_src  = 3'b000;
		joystick = 8'h00;
		build_table();
		repeat (10) @(posedge clk_cpu);
		@(negedge clk_cpu);
		reset = 1'b0;

		foreach (row_op[i])
			apply_row(i);
		repeat (4) @(negedge clk_cpu);

		chk_fails = gb_io_top_inst.irq_ctrl_inst.irq_chk.fails +
			gb_io_top_inst.work_ram_inst.ram_chk.fails;
		total = mon_errors + wait_fails + chk_fails;
		$display("errors: %0d (compare %0d of %0d checks, wait %0d, assertion %0d)",
			total, mon_errors, mon_checks, wait_fails, chk_fails);
		if (total == 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

/* verification/gb_io_monitor.sv */
// compares rdata or irq_n one cycle after the driver arms a check
// at most one check per cycle, compared on the falling edge
`timescale 1ns/1ps

module gb_io_monitor (
	input  logic       clk_cpu,
	input  logic [7:0] rdata,
	input  logic       irq_n,
	output int         errors,
	output int         checks
);

	string      req_name;
	logic [7:0] req_exp;
	logic       req_irq;          // 1 = compare irq_n instead of rdata
	int         req_seq = 0;
	int         seen_seq = 0;
	string      chk_name;
	logic [7:0] chk_exp;
	logic       chk_irq;
	logic       chk_valid = 1'b0;
	int         err_cnt = 0;
	int         chk_cnt = 0;

	assign errors = err_cnt;
	assign checks = chk_cnt;

	// called by the driver on the falling edge that starts the access
	task expect_byte(input string name, input logic [7:0] exp, input logic is_irq);
		req_name = name;
		req_exp  = exp;
		req_irq  = is_irq;
		req_seq++;
	endtask

	// the edge that samples the access takes the request over
	always @(posedge clk_cpu) begin
		chk_valid <= req_seq != seen_seq;
		seen_seq  <= req_seq;
		chk_name  <= req_name;
		chk_exp   <= req_exp;
		chk_irq   <= req_irq;
	end

	always @(negedge clk_cpu) begin
		if (chk_valid) begin
			chk_cnt++;
			if (chk_irq) begin
				if (irq_n !== chk_exp[0]) begin
					$display("** Error %s: expected irq_n %0b, actual %0b",
						chk_name, chk_exp[0], irq_n);
					err_cnt++;
				end
			end else if (rdata !== chk_exp) begin
				$display("** Error %s: expected %02h, actual %02h", chk_name, chk_exp, rdata);
				err_cnt++;
			end
		end
	end

endmodule

/* verification/gb_io_chk.sv */
// bus and irq invariants, bound into irq_ctrl and work_ram
// HAS_IRQ and HAS_BANK pick the checks that fit the bound module
`timescale 1ns/1ps
`include "gb_io_cfg.svh"

module gb_io_chk #(
	parameter bit HAS_IRQ  = 1'b1,
	parameter bit HAS_BANK = 1'b1
) (
	input  logic       clk_cpu,
	input  logic       reset,
	input  logic [1:0] hits,      // registered hit flags
	input  logic       irq_n,
	input  logic       pend_any,  // enabled flag pending, seen by the vector encoder
	input  logic [2:0] bank,
	output int         fails
);

	int irq_fails = 0;
	int bank_fails = 0;
	int hit_fails = 0;

	assign fails = irq_fails + bank_fails + hit_fails;

	// irq_n against the priority encoder, both must agree on IE & IF
	if (HAS_IRQ) begin : g_irq
		irq_level: assert property (@(posedge clk_cpu) disable iff (reset) irq_n == !pend_any)
			else begin
				$error("irq_n does not follow IE & IF");
				irq_fails++;
			end
	end

	if (HAS_BANK) begin : g_bank
		bank_nonzero: assert property (@(posedge clk_cpu) disable iff (reset) bank != 3'd0)
			else begin
				$error("work ram bank register holds 0");
				bank_fails++;
			end
	end

	// a hit never survives into a second cycle
	hit_single: assert property (@(posedge clk_cpu) disable iff (reset)
		(hits & $past(hits)) == 2'b00)
		else begin
			$error("hit flag high for more than one cycle");
			hit_fails++;
		end

endmodule

// irq_ctrl has no bank
bind irq_ctrl gb_io_chk #(.HAS_IRQ(1'b1), .HAS_BANK(1'b0)) irq_chk (
	.clk_cpu  (clk_cpu),
	.reset    (reset),
	.hits     ({if_hit, ie_hit}),
	.irq_n    (irq_n),
	.pend_any (irq_vec != `GB_IRQ_VEC_NONE),
	.bank     (3'd1),
	.fails    ()
);

// work_ram has no irq
bind work_ram gb_io_chk #(.HAS_IRQ(1'b0), .HAS_BANK(1'b1)) ram_chk (
	.clk_cpu  (clk_cpu),
	.reset    (reset),
	.hits     ({1'b0, hit}),
	.irq_n    (1'b1),
	.pend_any (1'b0),
	.bank     (bank_r),
	.fails    ()
);

/* design/gb_io_top.sv */
// io block around the cpu: interrupts, joypad, serial stub, wram, hram
// everything on the rising edge of clk_cpu, rdata one cycle after rd
`timescale 1ns/1ps

module gb_io_top (
	input  logic             clk_cpu,
	input  logic             reset,
	input  logic             is_gbc,
	input  gb_io_pkg::addr_t addr,
	input  gb_io_pkg::data_t wdata,
	input  logic             wr,
	input  logic             rd,
	input  logic             irq_ack,
	input  logic [2:0]       irq_src,   // vblank, lcd, timer pulses
	input  logic [7:0]       joystick,  // active high buttons
	output gb_io_pkg::data_t rdata,
	output logic             irq_n
);

	cpu_bus_if bus ();

	assign bus.addr  = addr;
	assign bus.wdata = wdata;
	assign bus.wr    = wr;
	assign bus.rd    = rd;

	// --------------------
	// peripherals
	logic             serial_irq;
	logic [7:0]       joy_lines;
	gb_io_pkg::data_t irq_vec;
	logic             if_hit, ie_hit, joy_hit, ser_hit, ram_hit;
	gb_io_pkg::data_t if_rdata, ie_rdata, joy_rdata, ser_rdata, ram_rdata;

	irq_ctrl irq_ctrl_inst (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.bus        (bus.periph),
		.irq_ack    (irq_ack),
		.irq_src    (irq_src),
		.serial_irq (serial_irq),
		.joy_lines  (joy_lines),
		.irq_n      (irq_n),
		.irq_vec    (irq_vec),
		.if_hit     (if_hit),
		.if_rdata   (if_rdata),
		.ie_hit     (ie_hit),
		.ie_rdata   (ie_rdata)
	);

	joypad joypad_inst (
		.clk_cpu   (clk_cpu),
		.reset     (reset),
		.bus       (bus.periph),
		.joystick  (joystick),
		.joy_lines (joy_lines),
		.hit       (joy_hit),
		.rdata     (joy_rdata)
	);

	serial_port serial_port_inst (
		.clk_cpu    (clk_cpu),
		.reset      (reset),
		.bus        (bus.periph),
		.serial_irq (serial_irq),
		.hit        (ser_hit),
		.rdata      (ser_rdata)
	);

	work_ram work_ram_inst (
		.clk_cpu (clk_cpu),
		.reset   (reset),
		.is_gbc  (is_gbc),
		.bus     (bus.periph),
		.hit     (ram_hit),
		.rdata   (ram_rdata)
	);

	// --------------------
	// read back
	bus_read_mux bus_read_mux_inst (
		.clk_cpu   (clk_cpu),
		.irq_ack   (irq_ack),
		.irq_vec   (irq_vec),
		.if_hit    (if_hit),
		.if_rdata  (if_rdata),
		.ie_hit    (ie_hit),
		.ie_rdata  (ie_rdata),
		.joy_hit   (joy_hit),
		.joy_rdata (joy_rdata),
		.ser_hit   (ser_hit),
		.ser_rdata (ser_rdata),
		.ram_hit   (ram_hit),
		.ram_rdata (ram_rdata),
		.rdata     (rdata)
	);

endmodule

/* design/work_ram.sv */
// 32 KiB work ram in 4 KiB banks plus 127 bytes of high ram
// FF70 only exists in colour mode, elsewhere D000 is always bank 1
`timescale 1ns/1ps
`include "gb_io_cfg.svh"

module work_ram (
	input  logic             clk_cpu,
	input  logic             reset,
	input  logic             is_gbc,
	cpu_bus_if.periph        bus,
	output logic             hit,
	output gb_io_pkg::data_t rdata
);

	localparam int WRAM_IDX_W = `GB_WRAM_BANK_W + 12;
	localparam int WRAM_DEPTH = 1 << WRAM_IDX_W;

	gb_io_pkg::data_t        wram [0:WRAM_DEPTH-1];
	gb_io_pkg::data_t        hram [0:126];
	gb_io_pkg::wram_bank_t   bank_r;    // SVBK, 1..7
	gb_io_pkg::wram_bank_t   bank_eff;
	logic [WRAM_IDX_W-1:0]   wram_idx;
	logic                    sel_wram, sel_hram, sel_svbk;

	// --------------------
	// decode
	assign sel_wram = (bus.addr >= `GB_WRAM_BASE) && (bus.addr <= `GB_WRAM_END);
	assign sel_hram = (bus.addr >= `GB_HRAM_BASE) && (bus.addr != `GB_REG_IE);
	assign sel_svbk = is_gbc && (bus.addr == `GB_REG_SVBK);

	// C000 half is fixed bank 0, D000 half is switchable
	always_comb begin
		if (!bus.addr[12])
			bank_eff = '0;
		else if (is_gbc)
			bank_eff = bank_r;
		else
			bank_eff = gb_io_pkg::wram_bank_t'(1);
	end

	// echo at E000 falls out of dropping address bit 13
	assign wram_idx = {bank_eff, bus.addr[11:0]};

	// --------------------
	// bank register and hit flag
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			bank_r <= gb_io_pkg::wram_bank_t'(1);
			hit    <= 1'b0;
		end else begin
			hit <= bus.rd && (sel_wram || sel_hram || sel_svbk);
			if (bus.wr && sel_svbk) begin
				if (bus.wdata[`GB_WRAM_BANK_W-1:0] == '0)
					bank_r <= gb_io_pkg::wram_bank_t'(1);  // 0 maps to 1
				else
					bank_r <= bus.wdata[`GB_WRAM_BANK_W-1:0];
			end
		end
	end

	// --------------------
	// ram arrays, read is registered
	always_ff @(posedge clk_cpu) begin
		if (bus.wr && sel_wram)
			wram[wram_idx] <= bus.wdata;
		if (bus.wr && sel_hram)
			hram[bus.addr[6:0]] <= bus.wdata;  // FF80..FFFE -> 0..126

		if (bus.rd) begin
			if (sel_svbk)
				rdata <= {{(`GB_DATA_W - `GB_WRAM_BANK_W){1'b1}}, bank_r};
			else if (sel_hram)
				rdata <= hram[bus.addr[6:0]];
			else
				rdata <= wram[wram_idx];  // ignored unless hit
		end
	end

endmodule

/* design/serial_port.sv */
// SC register and transfer timer only, no data is shifted
// internal clock only. A transfer is 8 divider wraps plus one cycle
`timescale 1ns/1ps
`include "gb_io_cfg.svh"

module serial_port (
	input  logic             clk_cpu,
	input  logic             reset,
	cpu_bus_if.periph        bus,
	output logic             serial_irq,  // one cycle at end of transfer
	output logic             hit,
	output gb_io_pkg::data_t rdata
);

	localparam int CNT_W = $clog2(`GB_SERIAL_BITS + 1);

	gb_io_pkg::serial_state_t state;
	gb_io_pkg::serial_div_t   div;      // bit time
	logic [CNT_W-1:0]         bit_cnt;  // bits still to go
	logic                     sc_start;
	logic                     sc_clk;   // 1 = internal clock
	logic                     sel;
	logic                     sc_wr;

	assign sel   = bus.addr == `GB_REG_SC;
	assign sc_wr = bus.wr && sel;

	// --------------------
	// transfer fsm
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			state      <= gb_io_pkg::serial_idle;
			sc_start   <= 1'b0;
			sc_clk     <= 1'b0;
			serial_irq <= 1'b0;
			div        <= '1;
			bit_cnt    <= '0;
		end else begin
			serial_irq <= 1'b0;
			if (sc_wr) begin
				sc_start <= bus.wdata[7];
				sc_clk   <= bus.wdata[0];
				div      <= '1;
				bit_cnt  <= CNT_W'(`GB_SERIAL_BITS);
				// start with internal clock runs, anything else stops
				if (bus.wdata[7] && bus.wdata[0])
					state <= gb_io_pkg::serial_shift;
				else
					state <= gb_io_pkg::serial_idle;
			end else begin
				case (state)
					gb_io_pkg::serial_shift: begin
						div <= div - 1'b1;
						if (bit_cnt == '0) begin  // all bits out
							serial_irq <= 1'b1;
							sc_start   <= 1'b0;
							state      <= gb_io_pkg::serial_idle;
						end else if (div == '0) begin
							bit_cnt <= bit_cnt - 1'b1;
						end
					end
					default: begin
						div <= '1;  // hold reload value while idle
					end
				endcase
			end
		end
	end

	// read back
	always_ff @(posedge clk_cpu) begin
		if (reset)
			hit <= 1'b0;
		else
			hit <= bus.rd && sel;
	end

	always_ff @(posedge clk_cpu) begin
		if (bus.rd && sel)
			rdata <= {sc_start, 6'h3F, sc_clk};
	end

endmodule

/* design/joypad.sv */
// P1 register at FF00, select bits low active as on the real part
// joystick bits 0..3 are right left up down, 4..7 the buttons
`timescale 1ns/1ps
`include "gb_io_cfg.svh"

module joypad (
	input  logic             clk_cpu,
	input  logic             reset,
	cpu_bus_if.periph        bus,
	input  logic [7:0]       joystick,   // active high
	output logic [7:0]       joy_lines,  // {directions, buttons} active low
	output logic             hit,
	output gb_io_pkg::data_t rdata
);

	logic [1:0] p54;    // P15 P14 select
	logic [3:0] dir_n;  // P14 nibble
	logic [3:0] btn_n;  // P15 nibble
	logic       sel;

	assign sel = bus.addr == `GB_REG_JOYP;

	// deselected nibble floats high
	assign dir_n     = ~joystick[3:0] | {4{p54[0]}};
	assign btn_n     = ~joystick[7:4] | {4{p54[1]}};
	assign joy_lines = {dir_n, btn_n};

	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			p54 <= 2'b00;
			hit <= 1'b0;
		end else begin
			hit <= bus.rd && sel;
			if (bus.wr && sel)
				p54 <= bus.wdata[5:4];  // only the select bits are writable
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (bus.rd && sel)
			rdata <= {2'b11, p54, dir_n & btn_n};
	end

endmodule

/* design/irq_ctrl.sv */
// IE/IF registers with fixed priority, vblank highest and joypad lowest
// the acknowledged flag clears on the falling edge of irq_ack
`timescale 1ns/1ps
`include "gb_io_cfg.svh"

module irq_ctrl (
	input  logic             clk_cpu,
	input  logic             reset,
	cpu_bus_if.periph        bus,
	input  logic             irq_ack,
	input  logic [2:0]       irq_src,     // vblank, lcd, timer
	input  logic             serial_irq,
	input  logic [7:0]       joy_lines,   // active low P1x lines
	output logic             irq_n,
	output gb_io_pkg::data_t irq_vec,
	output logic             if_hit,
	output gb_io_pkg::data_t if_rdata,
	output logic             ie_hit,
	output gb_io_pkg::data_t ie_rdata
);

	gb_io_pkg::irq_mask_t ie_r;
	gb_io_pkg::irq_mask_t if_r;
	gb_io_pkg::irq_mask_t pend;      // enabled and pending
	gb_io_pkg::irq_mask_t ack_clr;   // one hot, highest priority pending
	gb_io_pkg::irq_mask_t irq_set;
	logic [7:0]           joy_d1, joy_d2;  // two stage sampler
	logic                 ack_d;
	logic                 ack_fall;
	logic                 sel_if, sel_ie;

	assign sel_if = bus.addr == `GB_REG_IF;
	assign sel_ie = bus.addr == `GB_REG_IE;

	assign pend     = ie_r & if_r;
	assign irq_n    = ~|pend;                   // straight from the registers
	assign ack_clr  = pend & (~pend + 1'b1);    // isolate lowest set bit
	assign ack_fall = ack_d & ~irq_ack;

	// joypad flag on any line going 1 to 0
	assign irq_set = {|(joy_d2 & ~joy_d1), serial_irq, irq_src};

	// --------------------
	// rst vector, lowest index wins
	always_comb begin
		irq_vec = `GB_IRQ_VEC_NONE;
		for (int i = `GB_IRQ_N - 1; i >= 0; i--) begin
			if (pend[i])
				irq_vec = gb_io_pkg::data_t'(`GB_IRQ_VEC_BASE + `GB_IRQ_VEC_STEP * i);
		end
	end

	// --------------------
	// flag and enable registers
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			ie_r   <= '0;
			if_r   <= '0;
			ack_d  <= 1'b0;
			joy_d1 <= '1;  // lines idle high
			joy_d2 <= '1;
		end else begin
			joy_d1 <= joy_lines;
			joy_d2 <= joy_d1;
			ack_d  <= irq_ack;

			if (ack_fall)
				if_r <= (if_r | irq_set) & ~ack_clr;  // clear beats a new pulse
			else
				if_r <= if_r | irq_set;

			// cpu writes override everything else
			if (bus.wr && sel_if)
				if_r <= bus.wdata[`GB_IRQ_N-1:0];
			if (bus.wr && sel_ie)
				ie_r <= bus.wdata[`GB_IRQ_N-1:0];
		end
	end

	// read back, upper IF bits read as 1
	always_ff @(posedge clk_cpu) begin
		if (reset) begin
			if_hit <= 1'b0;
			ie_hit <= 1'b0;
		end else begin
			if_hit <= bus.rd && sel_if;
			ie_hit <= bus.rd && sel_ie;
		end
	end

	always_ff @(posedge clk_cpu) begin
		if (bus.rd && sel_if)
			if_rdata <= {{(`GB_DATA_W - `GB_IRQ_N){1'b1}}, if_r};
		if (bus.rd && sel_ie)
			ie_rdata <= {{(`GB_DATA_W - `GB_IRQ_N){1'b0}}, ie_r};
	end

endmodule

/* design/bus_read_mux.sv */
// picks the registered read byte of whichever source answered
// the vector wins while the ack is up, FF when nobody answers
`timescale 1ns/1ps
`include "gb_io_cfg.svh"

module bus_read_mux (
	input  logic             clk_cpu,
	input  logic             irq_ack,
	input  gb_io_pkg::data_t irq_vec,
	input  logic             if_hit,
	input  gb_io_pkg::data_t if_rdata,
	input  logic             ie_hit,
	input  gb_io_pkg::data_t ie_rdata,
	input  logic             joy_hit,
	input  gb_io_pkg::data_t joy_rdata,
	input  logic             ser_hit,
	input  gb_io_pkg::data_t ser_rdata,
	input  logic             ram_hit,
	input  gb_io_pkg::data_t ram_rdata,
	output gb_io_pkg::data_t rdata
);

	logic             ack_q;  // ack seen at the last edge
	gb_io_pkg::data_t vec_q;

	// vector sampled alongside the other sources
	always_ff @(posedge clk_cpu) begin
		ack_q <= irq_ack;
		if (irq_ack)
			vec_q <= irq_vec;  // frozen once ack drops
	end

	// fixed priority, normally only one hit at a time
	always_comb begin
		if (ack_q)
			rdata = vec_q;
		else if (if_hit)
			rdata = if_rdata;
		else if (ie_hit)
			rdata = ie_rdata;
		else if (joy_hit)
			rdata = joy_rdata;
		else if (ser_hit)
			rdata = ser_rdata;
		else if (ram_hit)
			rdata = ram_rdata;
		else
			rdata = `GB_IDLE_DATA;  // open bus
	end

endmodule

/* design/cpu_bus_if.sv */
// cpu side bus as seen by the peripherals
// strobes are active high, wr is one cycle per write
`timescale 1ns/1ps

interface cpu_bus_if;

	gb_io_pkg::addr_t addr;
	gb_io_pkg::data_t wdata;
	logic             wr;  // write strobe
	logic             rd;  // read strobe

	// every peripheral only listens
	modport periph (
		input addr,
		input wdata,
		input wr,
		input rd
	);

endinterface

/* design/gb_io_pkg.sv */
// shared types of the io block
// widths follow the cfg header
`include "gb_io_cfg.svh"

package gb_io_pkg;

	typedef logic [`GB_ADDR_W-1:0] addr_t;
	typedef logic [`GB_DATA_W-1:0] data_t;

	// bit 0 vblank, 1 lcd, 2 timer, 3 serial, 4 joypad
	typedef logic [`GB_IRQ_N-1:0] irq_mask_t;

	typedef logic [`GB_WRAM_BANK_W-1:0] wram_bank_t;  // 0 only ever used for C000 half
	typedef logic [`GB_SERIAL_DIV_W-1:0] serial_div_t;

	// serial transfer fsm
	typedef enum logic {
		serial_idle,
		serial_shift
	} serial_state_t;

endpackage

/* design/gb_io_cfg.svh */
// widths, register map and serial timing for the io block
// the serial bit time is 2**GB_SERIAL_DIV_W clocks of clk_cpu
`ifndef GB_IO_CFG_SVH
`define GB_IO_CFG_SVH

// bus and field widths
`define GB_ADDR_W        16
`define GB_DATA_W        8
`define GB_IRQ_N         5
`define GB_WRAM_BANK_W   3
`define GB_SERIAL_DIV_W  9  // 512 clocks per bit
`define GB_SERIAL_BITS   8

// --------------------
// register map
`define GB_REG_JOYP      16'hFF00
`define GB_REG_SC        16'hFF02
`define GB_REG_IF        16'hFF0F
`define GB_REG_SVBK      16'hFF70  // colour mode only
`define GB_REG_IE        16'hFFFF

// memory regions
`define GB_WRAM_BASE     16'hC000
`define GB_WRAM_END      16'hFDFF  // echo region included
`define GB_HRAM_BASE     16'hFF80

// read defaults and rst vectors
`define GB_IDLE_DATA     8'hFF
`define GB_IRQ_VEC_BASE  8'h40  // v-blank
`define GB_IRQ_VEC_STEP  8'h08
`define GB_IRQ_VEC_NONE  8'h55

`endif
